// ==== logic/tcb_params.svh ====
// bus widths, response delay and memory depth macros for the TCB subsystem
`ifndef TCB_PARAMS_SVH
`define TCB_PARAMS_SVH

//////////////////////////////////////////////////
// bus widths
//////////////////////////////////////////////////

// byte address width
`define TCB_ABW 16
// data width
`define TCB_DBW 32
// byte enables, one per data byte
`define TCB_BEW 4

//////////////////////////////////////////////////
// timing and memory
//////////////////////////////////////////////////

// cycles from transfer to response strobe
`define TCB_DLY 1
// memory depth in words
// word addresses at or above this are out of range
`define TCB_MEM_WORDS 256

`endif

// ==== logic/tcb_pkg.sv ====
// access size and arbiter state enums for the TCB subsystem
package tcb_pkg;

  //////////////////////////////////////////////////
  // manager access size
  //////////////////////////////////////////////////

  // encoded as log2 of the byte count
  typedef enum logic [1:0] {
    // 1 byte
    SIZ_BYTE = 2'd0,
    // 2 bytes
    SIZ_HALF = 2'd1,
    // 4 bytes, full bus width
    SIZ_WORD = 2'd2
  } tcb_size_t;

  //////////////////////////////////////////////////
  // arbiter grant state
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    // round-robin between both ports
    ARB_FREE  = 2'd0,
    // port 0 holds the bus until lck drops
    ARB_LOCK0 = 2'd1,
    // port 1 holds the bus until lck drops
    ARB_LOCK1 = 2'd2
  } arb_state_t;

endpackage : tcb_pkg

// ==== logic/tcb_access_align.sv ====
// sized access aligner with byte enables, misalignment reject and read data extension
`timescale 1ns/1ns
`include "tcb_params.svh"

module tcb_access_align (
  input  logic                tcb,
  input  logic                rst,
  // manager side, sized access
  input  logic                man_vld,
  input  logic                man_wen,
  input  tcb_pkg::tcb_size_t  man_siz,
  input  logic                man_uns,
  input  logic                man_lck,
  input  logic [`TCB_ABW-1:0] man_adr,
  input  logic [`TCB_DBW-1:0] man_wdt,
  output logic                man_rdy,
  output logic                man_rsp,
  output logic [`TCB_DBW-1:0] man_rdt,
  output logic                man_err,
  // bus side, one transfer with byte enables
  output logic                sub_vld,
  output logic                sub_wen,
  output logic                sub_lck,
  output logic [`TCB_ABW-1:0] sub_adr,
  output logic [`TCB_BEW-1:0] sub_ben,
  output logic [`TCB_DBW-1:0] sub_wdt,
  input  logic                sub_rdy,
  input  logic                sub_rsp,
  input  logic [`TCB_DBW-1:0] sub_rdt,
  input  logic                sub_err
);
  import tcb_pkg::*;

  // byte offset bits inside a bus word
  localparam int unsigned OFW = $clog2(`TCB_BEW);

  // request decode
  logic [OFW-1:0]      req_off;
  logic                req_mis;
  logic [`TCB_BEW-1:0] req_ben;
  logic [`TCB_DBW-1:0] req_msk;

  // access attributes in flight
  tcb_size_t           dly_siz [`TCB_DLY];
  logic [OFW-1:0]      dly_off [`TCB_DLY];
  logic                dly_uns [`TCB_DLY];

  // response side
  logic                rej_rsp;
  tcb_size_t           rsp_siz;
  logic [OFW-1:0]      rsp_off;
  logic                rsp_uns;
  logic [`TCB_DBW-1:0] rsp_sft;
  logic                rsp_sgn;
  logic [`TCB_DBW-1:0] rsp_ext;

  //////////////////////////////////////////////////
  // request path
  //////////////////////////////////////////////////

  assign req_off = man_adr[OFW-1:0];

  // enables and data mask at lane 0, misaligned check
  always_comb begin
    case (man_siz)
      SIZ_BYTE: begin
        req_mis = 1'b0;
        req_ben = {{(`TCB_BEW-1){1'b0}}, 1'b1};
        req_msk = {{(`TCB_DBW-8){1'b0}}, 8'hff};
      end
      SIZ_HALF: begin
        req_mis = req_off[0];
        req_ben = {{(`TCB_BEW-2){1'b0}}, 2'b11};
        req_msk = {{(`TCB_DBW-16){1'b0}}, 16'hffff};
      end
      SIZ_WORD: begin
        req_mis = |req_off;
        req_ben = '1;
        req_msk = '1;
      end
      default: begin
        // unknown size never reaches the bus
        req_mis = 1'b1;
        req_ben = '0;
        req_msk = '0;
      end
    endcase
  end

  // misaligned access is kept off the bus
  assign sub_vld = man_vld & ~req_mis;
  assign sub_wen = man_wen;
  assign sub_lck = man_lck;
  // word address, lanes picked by ben
  assign sub_adr = {man_adr[`TCB_ABW-1:OFW], {OFW{1'b0}}};
  assign sub_ben = req_ben << req_off;
  assign sub_wdt = (man_wdt & req_msk) << {req_off, 3'b000};

  // rejects are accepted locally in the same cycle
  assign man_rdy = req_mis | sub_rdy;

  //////////////////////////////////////////////////
  // response path
  //////////////////////////////////////////////////

  // local err strobe one cycle after a reject
  always_ff @(posedge tcb) begin
    if (rst) begin
      rej_rsp <= 1'b0;
    end else begin
      rej_rsp <= man_vld & req_mis;
    end
  end

  // size, offset and uns follow the bus delay
  always_ff @(posedge tcb) begin
    dly_siz[0] <= man_siz;
    dly_off[0] <= req_off;
    dly_uns[0] <= man_uns;
    for (int i = 1; i < `TCB_DLY; i++) begin
      dly_siz[i] <= dly_siz[i-1];
      dly_off[i] <= dly_off[i-1];
      dly_uns[i] <= dly_uns[i-1];
    end
  end

  assign rsp_siz = dly_siz[`TCB_DLY-1];
  assign rsp_off = dly_off[`TCB_DLY-1];
  assign rsp_uns = dly_uns[`TCB_DLY-1];

  // addressed lanes back down to bit 0
  assign rsp_sft = sub_rdt >> {rsp_off, 3'b000};

  // sign or zero extension
  always_comb begin
    case (rsp_siz)
      SIZ_BYTE: begin
        rsp_sgn = ~rsp_uns & rsp_sft[7];
        rsp_ext = {{(`TCB_DBW-8){rsp_sgn}}, rsp_sft[7:0]};
      end
      SIZ_HALF: begin
        rsp_sgn = ~rsp_uns & rsp_sft[15];
        rsp_ext = {{(`TCB_DBW-16){rsp_sgn}}, rsp_sft[15:0]};
      end
      default: begin
        rsp_sgn = 1'b0;
        rsp_ext = rsp_sft;
      end
    endcase
  end

  // bus and local responses never share a cycle
  assign man_rsp = sub_rsp | rej_rsp;
  assign man_err = rej_rsp | sub_err;
  assign man_rdt = rej_rsp ? '0 : rsp_ext;

endmodule : tcb_access_align

// ==== logic/tcb_arbiter.sv ====
// two port round-robin TCB arbiter with lock hold and response routing
`timescale 1ns/1ns
`include "tcb_params.svh"

module tcb_arbiter (
  input  logic                tcb,
  input  logic                rst,
  // port 0
  input  logic                s0_vld,
  input  logic                s0_wen,
  input  logic                s0_lck,
  input  logic [`TCB_ABW-1:0] s0_adr,
  input  logic [`TCB_BEW-1:0] s0_ben,
  input  logic [`TCB_DBW-1:0] s0_wdt,
  output logic                s0_rdy,
  output logic                s0_rsp,
  output logic [`TCB_DBW-1:0] s0_rdt,
  output logic                s0_err,
  // port 1
  input  logic                s1_vld,
  input  logic                s1_wen,
  input  logic                s1_lck,
  input  logic [`TCB_ABW-1:0] s1_adr,
  input  logic [`TCB_BEW-1:0] s1_ben,
  input  logic [`TCB_DBW-1:0] s1_wdt,
  output logic                s1_rdy,
  output logic                s1_rsp,
  output logic [`TCB_DBW-1:0] s1_rdt,
  output logic                s1_err,
  // shared memory
  output logic                mem_vld,
  output logic                mem_wen,
  output logic [`TCB_ABW-1:0] mem_adr,
  output logic [`TCB_BEW-1:0] mem_ben,
  output logic [`TCB_DBW-1:0] mem_wdt,
  input  logic                mem_rsp,
  input  logic [`TCB_DBW-1:0] mem_rdt,
  input  logic                mem_err
);
  import tcb_pkg::*;

  arb_state_t state;
  // round-robin pointer, low favours port 0
  logic       ptr;
  logic       gnt0;
  logic       gnt1;
  logic       trn0;
  logic       trn1;
  // owner per transfer in flight, high for port 1
  logic       own [`TCB_DLY];
  logic       rsp_own;

  //////////////////////////////////////////////////
  // grant
  //////////////////////////////////////////////////

  always_comb begin
    case (state)
      ARB_LOCK0: begin
        gnt0 = 1'b1;
        gnt1 = 1'b0;
      end
      ARB_LOCK1: begin
        gnt0 = 1'b0;
        gnt1 = 1'b1;
      end
      default: begin
        // pointer breaks the tie
        gnt0 = s0_vld & (~s1_vld | ~ptr);
        gnt1 = s1_vld & (~s0_vld |  ptr);
      end
    endcase
  end

  assign s0_rdy = gnt0;
  assign s1_rdy = gnt1;

  assign trn0 = s0_vld & gnt0;
  assign trn1 = s1_vld & gnt1;

  // request mux
  assign mem_vld = trn0 | trn1;
  assign mem_wen = gnt1 ? s1_wen : s0_wen;
  assign mem_adr = gnt1 ? s1_adr : s0_adr;
  assign mem_ben = gnt1 ? s1_ben : s0_ben;
  assign mem_wdt = gnt1 ? s1_wdt : s0_wdt;

  //////////////////////////////////////////////////
  // lock state and pointer
  //////////////////////////////////////////////////

  always_ff @(posedge tcb) begin
    if (rst) begin
      state <= ARB_FREE;
      ptr   <= 1'b0;
    end else if (trn0) begin
      // lck low ends a locked sequence
      state <= s0_lck ? ARB_LOCK0 : ARB_FREE;
      ptr   <= 1'b1;
    end else if (trn1) begin
      state <= s1_lck ? ARB_LOCK1 : ARB_FREE;
      ptr   <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // response routing
  //////////////////////////////////////////////////

  // qualified by mem_rsp, so no valid bit is kept
  always_ff @(posedge tcb) begin
    own[0] <= gnt1;
    for (int i = 1; i < `TCB_DLY; i++) begin
      own[i] <= own[i-1];
    end
  end

  assign rsp_own = own[`TCB_DLY-1];

  assign s0_rsp = mem_rsp & ~rsp_own;
  assign s1_rsp = mem_rsp &  rsp_own;
  assign s0_rdt = mem_rdt;
  assign s1_rdt = mem_rdt;
  assign s0_err = mem_err & ~rsp_own;
  assign s1_err = mem_err &  rsp_own;

endmodule : tcb_arbiter

// ==== logic/tcb_mem.sv ====
// TCB subordinate word memory with byte enables and out-of-range error
`timescale 1ns/1ns
`include "tcb_params.svh"

module tcb_mem (
  input  logic                tcb,
  input  logic                rst,
  // request, always accepted
  input  logic                vld,
  input  logic                wen,
  input  logic [`TCB_ABW-1:0] adr,
  input  logic [`TCB_BEW-1:0] ben,
  input  logic [`TCB_DBW-1:0] wdt,
  // response one cycle after the request
  output logic                rsp,
  output logic [`TCB_DBW-1:0] rdt,
  output logic                err
);

  localparam int unsigned OFW = $clog2(`TCB_BEW);
  localparam int unsigned MAW = $clog2(`TCB_MEM_WORDS);

  logic [`TCB_DBW-1:0]     mem [`TCB_MEM_WORDS];
  // word address and array index
  logic [`TCB_ABW-OFW-1:0] wrd;
  logic [MAW-1:0]          idx;
  logic                    inr;

  //////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////

  assign wrd = adr[`TCB_ABW-1:OFW];
  assign idx = wrd[MAW-1:0];
  assign inr = (wrd < `TCB_MEM_WORDS);

  //////////////////////////////////////////////////
  // write
  //////////////////////////////////////////////////

  // enabled bytes only
  always_ff @(posedge tcb) begin
    if (vld & wen & inr) begin
      for (int b = 0; b < `TCB_BEW; b++) begin
        if (ben[b]) begin
          mem[idx][8*b +: 8] <= wdt[8*b +: 8];
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // response
  //////////////////////////////////////////////////

  always_ff @(posedge tcb) begin
    if (rst) begin
      rsp <= 1'b0;
    end else begin
      rsp <= vld;
    end
  end

  // whole word on reads, zero on writes and errors
  always_ff @(posedge tcb) begin
    rdt <= (vld & ~wen & inr) ? mem[idx] : '0;
    err <= vld & ~inr;
  end

endmodule : tcb_mem

// ==== logic/tcb_subsystem_top.sv ====
// two manager TCB subsystem with aligners, arbiter and shared memory
`timescale 1ns/1ns
`include "tcb_params.svh"

module tcb_subsystem_top (
  input  logic                tcb,
  input  logic                rst,
  // manager 0
  input  logic                m0_vld,
  input  logic                m0_wen,
  input  tcb_pkg::tcb_size_t  m0_siz,
  input  logic                m0_uns,
  input  logic                m0_lck,
  input  logic [`TCB_ABW-1:0] m0_adr,
  input  logic [`TCB_DBW-1:0] m0_wdt,
  output logic                m0_rdy,
  output logic                m0_rsp,
  output logic [`TCB_DBW-1:0] m0_rdt,
  output logic                m0_err,
  // manager 1
  input  logic                m1_vld,
  input  logic                m1_wen,
  input  tcb_pkg::tcb_size_t  m1_siz,
  input  logic                m1_uns,
  input  logic                m1_lck,
  input  logic [`TCB_ABW-1:0] m1_adr,
  input  logic [`TCB_DBW-1:0] m1_wdt,
  output logic                m1_rdy,
  output logic                m1_rsp,
  output logic [`TCB_DBW-1:0] m1_rdt,
  output logic                m1_err
);

  //////////////////////////////////////////////////
  // aligner to arbiter transfers
  //////////////////////////////////////////////////

  // port 0
  logic                a0_vld;
  logic                a0_wen;
  logic                a0_lck;
  logic [`TCB_ABW-1:0] a0_adr;
  logic [`TCB_BEW-1:0] a0_ben;
  logic [`TCB_DBW-1:0] a0_wdt;
  logic                a0_rdy;
  logic                a0_rsp;
  logic [`TCB_DBW-1:0] a0_rdt;
  logic                a0_err;
  // port 1
  logic                a1_vld;
  logic                a1_wen;
  logic                a1_lck;
  logic [`TCB_ABW-1:0] a1_adr;
  logic [`TCB_BEW-1:0] a1_ben;
  logic [`TCB_DBW-1:0] a1_wdt;
  logic                a1_rdy;
  logic                a1_rsp;
  logic [`TCB_DBW-1:0] a1_rdt;
  logic                a1_err;

  // arbiter to memory
  logic                mem_vld;
  logic                mem_wen;
  logic [`TCB_ABW-1:0] mem_adr;
  logic [`TCB_BEW-1:0] mem_ben;
  logic [`TCB_DBW-1:0] mem_wdt;
  logic                mem_rsp;
  logic [`TCB_DBW-1:0] mem_rdt;
  logic                mem_err;

  //////////////////////////////////////////////////
  // instances
  //////////////////////////////////////////////////

  tcb_access_align u_align0 (
    .tcb     (tcb),     .rst     (rst),
    .man_vld (m0_vld),  .man_wen (m0_wen),  .man_siz (m0_siz),  .man_uns (m0_uns),
    .man_lck (m0_lck),  .man_adr (m0_adr),  .man_wdt (m0_wdt),
    .man_rdy (m0_rdy),  .man_rsp (m0_rsp),  .man_rdt (m0_rdt),  .man_err (m0_err),
    .sub_vld (a0_vld),  .sub_wen (a0_wen),  .sub_lck (a0_lck),  .sub_adr (a0_adr),
    .sub_ben (a0_ben),  .sub_wdt (a0_wdt),
    .sub_rdy (a0_rdy),  .sub_rsp (a0_rsp),  .sub_rdt (a0_rdt),  .sub_err (a0_err)
  );

  tcb_access_align u_align1 (
    .tcb     (tcb),     .rst     (rst),
    .man_vld (m1_vld),  .man_wen (m1_wen),  .man_siz (m1_siz),  .man_uns (m1_uns),
    .man_lck (m1_lck),  .man_adr (m1_adr),  .man_wdt (m1_wdt),
    .man_rdy (m1_rdy),  .man_rsp (m1_rsp),  .man_rdt (m1_rdt),  .man_err (m1_err),
    .sub_vld (a1_vld),  .sub_wen (a1_wen),  .sub_lck (a1_lck),  .sub_adr (a1_adr),
    .sub_ben (a1_ben),  .sub_wdt (a1_wdt),
    .sub_rdy (a1_rdy),  .sub_rsp (a1_rsp),  .sub_rdt (a1_rdt),  .sub_err (a1_err)
  );

  tcb_arbiter u_arbiter (
    .tcb     (tcb),     .rst     (rst),
    .s0_vld  (a0_vld),  .s0_wen  (a0_wen),  .s0_lck  (a0_lck),  .s0_adr  (a0_adr),
    .s0_ben  (a0_ben),  .s0_wdt  (a0_wdt),
    .s0_rdy  (a0_rdy),  .s0_rsp  (a0_rsp),  .s0_rdt  (a0_rdt),  .s0_err  (a0_err),
    .s1_vld  (a1_vld),  .s1_wen  (a1_wen),  .s1_lck  (a1_lck),  .s1_adr  (a1_adr),
    .s1_ben  (a1_ben),  .s1_wdt  (a1_wdt),
    .s1_rdy  (a1_rdy),  .s1_rsp  (a1_rsp),  .s1_rdt  (a1_rdt),  .s1_err  (a1_err),
    .mem_vld (mem_vld), .mem_wen (mem_wen), .mem_adr (mem_adr), .mem_ben (mem_ben),
    .mem_wdt (mem_wdt),
    .mem_rsp (mem_rsp), .mem_rdt (mem_rdt), .mem_err (mem_err)
  );

  tcb_mem u_mem (
    .tcb (tcb),
    .rst (rst),
    .vld (mem_vld),
    .wen (mem_wen),
    .adr (mem_adr),
    .ben (mem_ben),
    .wdt (mem_wdt),
    .rsp (mem_rsp),
    .rdt (mem_rdt),
    .err (mem_err)
  );

endmodule : tcb_subsystem_top

// ==== sim/tcb_subsystem_tb.sv ====
// testbench for the two manager TCB subsystem with file driven accesses, checks and timeout
`timescale 1ns/1ns
`include "tcb_params.svh"

module tcb_subsystem_tb;
  import tcb_pkg::*;

  // stimulus table of 9 fields per access
  localparam int MAX_LINES = 64;
  localparam int FIELDS    = 9;

  logic                tcb;
  logic                rst;
  // manager 0
  logic                m0_vld;
  logic                m0_wen;
  tcb_size_t           m0_siz;
  logic                m0_uns;
  logic                m0_lck;
  logic [`TCB_ABW-1:0] m0_adr;
  logic [`TCB_DBW-1:0] m0_wdt;
  logic                m0_rdy;
  logic                m0_rsp;
  logic [`TCB_DBW-1:0] m0_rdt;
  logic                m0_err;
  // manager 1
  logic                m1_vld;
  logic                m1_wen;
  tcb_size_t           m1_siz;
  logic                m1_uns;
  logic                m1_lck;
  logic [`TCB_ABW-1:0] m1_adr;
  logic [`TCB_DBW-1:0] m1_wdt;
  logic                m1_rdy;
  logic                m1_rsp;
  logic [`TCB_DBW-1:0] m1_rdt;
  logic                m1_err;

  logic [31:0]         stim [FIELDS*MAX_LINES];
  int                  nlines;
  int                  errors = 0;
  int                  checks = 0;
  int                  cycles = 0;
  int                  cycle_limit = 0;
  // line numbers per port for side by side groups
  int                  q0 [$];
  int                  q1 [$];

  tcb_subsystem_top i_tcb_subsystem_top (.*);

  //////////////////////////////////////////////////
  // clock and timeout
  //////////////////////////////////////////////////

  initial begin
    tcb = 1'b0;
    forever #2 tcb = ~tcb;
  end

  always @(posedge tcb) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout, run stopped after %0d cycles", cycles);
      report_and_finish(1'b1);
    end
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      $display("FAIL %s expected %08h actual %08h", name, exp, act);
      errors++;
    end
  endtask

  task automatic report_and_finish(input logic abort);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0 && !abort) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  function automatic logic port_rdy(input int p);
    return (p == 0) ? m0_rdy : m1_rdy;
  endfunction

  function automatic logic port_rsp(input int p);
    return (p == 0) ? m0_rsp : m1_rsp;
  endfunction

  function automatic logic port_err(input int p);
    return (p == 0) ? m0_err : m1_err;
  endfunction

  function automatic logic [`TCB_DBW-1:0] port_rdt(input int p);
    return (p == 0) ? m0_rdt : m1_rdt;
  endfunction

  // one stimulus line onto a manager port
  task automatic drive_request(input int p, input int ln);
    int b;
    b = FIELDS * ln;
    if (p == 0) begin
      m0_vld = 1'b1;
      m0_wen = stim[b+1][0];
      m0_siz = tcb_size_t'(stim[b+2][1:0]);
      m0_uns = stim[b+3][0];
      m0_lck = stim[b+4][0];
      m0_adr = stim[b+5][`TCB_ABW-1:0];
      m0_wdt = stim[b+6];
    end else begin
      m1_vld = 1'b1;
      m1_wen = stim[b+1][0];
      m1_siz = tcb_size_t'(stim[b+2][1:0]);
      m1_uns = stim[b+3][0];
      m1_lck = stim[b+4][0];
      m1_adr = stim[b+5][`TCB_ABW-1:0];
      m1_wdt = stim[b+6];
    end
  endtask

  // entered and left on a falling edge
  task automatic run_access(input int p, input int ln);
    int                  b;
    int                  gap;
    int                  lat;
    logic                acc;
    logic                exp_err;
    logic [`TCB_DBW-1:0] exp_rdt;
    string               name;
    b       = FIELDS * ln;
    exp_rdt = stim[b+7];
    exp_err = stim[b+8][0];
    name    = $sformatf("access %0d port %0d", ln + 1, p);
    drive_request(p, ln);
    // request held until rdy is seen high mid cycle
    acc = 1'b0;
    while (!acc) begin
      #1;
      acc = port_rdy(p);
      @(negedge tcb);
    end
    if (p == 0) begin
      m0_vld = 1'b0;
    end else begin
      m1_vld = 1'b0;
    end
    // response due in the cycle after the transfer
    lat = 1;
    while (!port_rsp(p)) begin
      @(negedge tcb);
      lat++;
    end
    check_value({name, " rsp delay"}, 32'd1, 32'(lat));
    check_value({name, " err"}, 32'(exp_err), 32'(port_err(p)));
    // rdt checked on reads and on rejects
    if (!stim[b+1][0] || exp_err) begin
      check_value({name, " rdt"}, exp_rdt, port_rdt(p));
    end
    gap = int'($urandom % 4);
    repeat (gap) @(negedge tcb);
  endtask

  task automatic run_port_list(input int p);
    int k;
    int n;
    n = (p == 0) ? q0.size() : q1.size();
    for (k = 0; k < n; k++) begin
      run_access(p, (p == 0) ? q0[k] : q1[k]);
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    int ln;
    int mode;
    rst    = 1'b1;
    m0_vld = 1'b0;
    m0_wen = 1'b0;
    m0_siz = SIZ_BYTE;
    m0_uns = 1'b0;
    m0_lck = 1'b0;
    m0_adr = '0;
    m0_wdt = '0;
    m1_vld = 1'b0;
    m1_wen = 1'b0;
    m1_siz = SIZ_BYTE;
    m1_uns = 1'b0;
    m1_lck = 1'b0;
    m1_adr = '0;
    m1_wdt = '0;
    void'($urandom(32'hf5827d8e));
    $readmemh("sim/tcb_stimulus.txt", stim);

    // lines up to the end marker
    nlines = 0;
    while (nlines < MAX_LINES && stim[FIELDS*nlines] !== 32'hf) begin
      nlines++;
    end

    if (nlines == MAX_LINES) begin
      $display("stimulus file has no end marker");
      errors++;
    end else begin
      cycle_limit = 20 * nlines + 50;
      repeat (4) @(negedge tcb);
      rst = 1'b0;

      ln = 0;
      while (ln < nlines) begin
        mode = int'(stim[FIELDS*ln]);
        if (mode == 2 || mode == 3) begin
          // adjacent 2/3 lines start on both ports together
          q0.delete();
          q1.delete();
          while (ln < nlines && (stim[FIELDS*ln] == 2 || stim[FIELDS*ln] == 3)) begin
            if (stim[FIELDS*ln] == 2) begin
              q0.push_back(ln);
            end else begin
              q1.push_back(ln);
            end
            ln++;
          end
          fork
            run_port_list(0);
            run_port_list(1);
          join
        end else begin
          run_access(mode, ln);
          ln++;
        end
      end
    end
    report_and_finish(1'b0);
  end

endmodule : tcb_subsystem_tb

// ==== verilog.f ====
+incdir+logic
logic/tcb_pkg.sv
logic/tcb_access_align.sv
logic/tcb_arbiter.sv
logic/tcb_mem.sv
logic/tcb_subsystem_top.sv
sim/tcb_subsystem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the TCB subsystem testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
  -f verilog.f \
  --top-module tcb_subsystem_tb \
  -Mdir obj_dir

./obj_dir/Vtcb_subsystem_tb > sim.log 2>&1
cat sim.log

if grep -q "Test failed" sim.log; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi
if ! grep -q "Test passed" sim.log; then
  echo "simulation ended without a result, see sim.log"
  exit 1
fi

// ==== sim/tcb_stimulus.txt ====
// columns, hex: mode wen siz uns lck adr wdt exp_rdt exp_err
// mode 0 port 0, 1 port 1, 2 and 3 port 0 and 1 side by side with adjacent 2/3 lines, f end
2 1 2 0 0 0040 aaaa0000 00000000 0
3 1 2 0 0 0040 bbbb1111 00000000 0
1 0 2 0 0 0040 00000000 bbbb1111 0
2 1 2 0 0 0030 c0c0c0c0 00000000 0
3 1 2 0 0 0034 0d0d0d0d 00000000 0
0 0 2 0 0 0030 00000000 c0c0c0c0 0
2 0 2 0 0 0034 00000000 0d0d0d0d 0
3 0 2 0 0 0030 00000000 c0c0c0c0 0
0 1 2 0 0 0010 12345678 00000000 0
0 0 2 0 0 0010 00000000 12345678 0
1 1 2 0 0 0020 11223344 00000000 0
1 1 0 0 0 0021 5a5a5aa5 00000000 0
1 1 1 0 0 0022 77778001 00000000 0
1 0 0 0 0 0021 00000000 ffffffa5 0
0 0 0 1 0 0021 00000000 000000a5 0
1 0 0 0 0 0020 00000000 00000044 0
0 0 1 0 0 0022 00000000 ffff8001 0
1 0 1 1 0 0022 00000000 00008001 0
0 0 1 0 0 0020 00000000 ffffa544 0
0 1 1 0 0 0021 0000ffff 00000000 1
1 1 2 0 0 0022 deadbeef 00000000 1
0 0 2 0 0 0023 00000000 00000000 1
1 0 2 0 0 0020 00000000 8001a544 0
1 0 2 0 0 0400 00000000 00000000 1
0 1 0 0 0 0ffc 000000ff 00000000 1
0 0 2 0 0 0010 00000000 12345678 0
3 1 2 0 1 0050 11111111 00000000 0
3 0 2 0 0 0050 00000000 11111111 0
2 1 2 0 0 0050 22222222 00000000 0
0 0 2 0 0 0050 00000000 22222222 0
f 0 0 0 0 0000 00000000 00000000 0
